//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rvfi_tracer_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# The simulator status is masked by tee, so the log decides the result.
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/rvfi_tracer_sva.sv
// Bound to rvfi_tracer; checks record framing only, field values are checked by the testbench.
module rvfi_tracer_sva
    import rvfi_pkg::*;
(
    input logic        clk_i,
    input logic        rst_n_i,
    input rvfi_instr_t rvfi_o
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [63:0] last_order;
    logic        seen_rec; // At least one record since reset.

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            last_order <= '0;
            seen_rec   <= 1'b0;
        end else if (rvfi_o.valid) begin
            last_order <= rvfi_o.order;
            seen_rec   <= 1'b1;
        end
    end

    // Reset is synchronous, so valid is low from the cycle after a reset edge.
    a_reset_quiet: assert property (@(posedge clk_i) !rst_n_i |=> !rvfi_o.valid)
        else $error("record valid during reset");

    a_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rvfi_o.valid |=> !rvfi_o.valid)
        else $error("record valid in two consecutive cycles");

    a_order_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rvfi_o.valid && seen_rec) |-> (rvfi_o.order == last_order + 64'd1))
        else $error("order did not advance by one");

endmodule

bind rvfi_tracer rvfi_tracer_sva u_sva (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .rvfi_o (rvfi_o)
);

//--- bench/rvfi_tracer_tb.sv
// Drives inputs on the rising edge and samples on the falling edge; compressed issue is not exercised.
`include "rvfi_cfg.svh"

module rvfi_tracer_tb
    import rvfi_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {STEP_WRITE, STEP_READ, STEP_INSN} step_kind_e;

    // One table row: a register access or an issue-then-commit pair.
    typedef struct packed {
        step_kind_e kind;
        logic [1:0] addr;
        xlen_t      data;     // Write data, or the expected read value.
        insn_t      insn;
        trans_id_t  id;
        xlen_t      pc;
        reg_addr_t  rd;
        xlen_t      result;
        logic       is_mem;
        xlen_t      mem_addr;
        logic       trap;
        priv_lvl_t  priv;
        logic       flush;    // Flush between issue and commit.
        logic       exp_rec;  // A record is expected.
    } step_t;

    logic          clk_i = 1'b0;
    logic          rst_n_i, flush_i, issue_valid_i, issue_compressed_i;
    trans_id_t     issue_pointer_i;
    insn_t         issue_insn_i;
    logic          commit_ack_i, ex_valid_i, reg_we_i;
    commit_instr_t commit_instr_i;
    priv_lvl_t     priv_lvl_i;
    logic [1:0]    reg_addr_i;
    xlen_t         reg_wdata_i, reg_rdata_o;
    rvfi_instr_t   rvfi_o;

    step_t       steps[$];
    int          n_rows = 0;
    int          err_cnt = 0;
    int          pass_rows = 0;
    int          fail_rows = 0;
    logic [63:0] exp_order = '0; // Advances only on expected records.

    rvfi_tracer u_dut (.*);

    always #10 clk_i = ~clk_i;

    function automatic step_t reg_step(step_kind_e kind, logic [1:0] addr, xlen_t data);
        step_t s;
        s = '0;
        s.kind = kind;
        s.addr = addr;
        s.data = data;
        return s;
    endfunction

    function automatic step_t insn_step(insn_t insn, trans_id_t id, xlen_t pc, reg_addr_t rd,
                                        xlen_t result, logic is_mem, xlen_t mem_addr,
                                        logic trap, priv_lvl_t priv, logic flush, logic exp_rec);
        step_t s;
        s = '0;
        s.kind = STEP_INSN;
        s.insn = insn;
        s.id = id;
        s.pc = pc;
        s.rd = rd;
        s.result = result;
        s.is_mem = is_mem;
        s.mem_addr = mem_addr;
        s.trap = trap;
        s.priv = priv;
        s.flush = flush;
        s.exp_rec = exp_rec;
        return s;
    endfunction

    task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_insn(input string name, input insn_t got, input insn_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_priv(input string name, input priv_lvl_t got, input priv_lvl_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic apply_insn(input step_t s);
        commit_instr_t ci;
        ci = '{trans_id: s.id, pc: s.pc, rd: s.rd, result: s.result,
               is_mem: s.is_mem, mem_addr: s.mem_addr};
        @(posedge clk_i);
        issue_valid_i   <= 1'b1;
        issue_pointer_i <= s.id;
        issue_insn_i    <= s.insn;
        @(posedge clk_i);
        issue_valid_i <= 1'b0;
        if (s.flush) begin
            flush_i <= 1'b1;
            @(posedge clk_i);
            flush_i <= 1'b0;
        end
        commit_ack_i   <= 1'b1;
        commit_instr_i <= ci;
        ex_valid_i     <= s.trap;
        priv_lvl_i     <= s.priv;
        @(posedge clk_i);
        commit_ack_i <= 1'b0;
        @(posedge clk_i);
        @(negedge clk_i); // Record is registered two edges after the commit drive.
        if (s.exp_rec && !rvfi_o.valid) begin
            $display("Expected a retirement record but valid stayed low");
            err_cnt++;
        end else if (!s.exp_rec && rvfi_o.valid) begin
            $display("Got a retirement record where none was expected");
            err_cnt++;
        end else if (s.exp_rec) begin
            check_xlen("order", rvfi_o.order[31:0], exp_order[31:0]);
            check_insn("insn", rvfi_o.insn, s.insn);
            check_xlen("pc_rdata", rvfi_o.pc_rdata, s.pc);
            check_bit("trap", rvfi_o.trap, s.trap);
            check_priv("mode", rvfi_o.mode, s.priv);
            check_reg("rd_addr", rvfi_o.rd_addr, s.trap ? 5'd0 : s.rd);
            check_xlen("rd_wdata", rvfi_o.rd_wdata,
                       (s.trap || s.rd == 5'd0) ? 32'd0 : s.result);
            check_xlen("mem_addr", rvfi_o.mem_addr, s.is_mem ? s.mem_addr : 32'd0);
            exp_order = exp_order + 64'd1;
        end
    endtask

    initial begin
        int errs_before;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        issue_valid_i = 1'b0;
        issue_compressed_i = 1'b0;
        issue_pointer_i = '0;
        issue_insn_i = '0;
        commit_ack_i = 1'b0;
        commit_instr_i = '0;
        ex_valid_i = 1'b0;
        priv_lvl_i = PRIV_M;
        reg_we_i = 1'b0;
        reg_addr_i = '0;
        reg_wdata_i = '0;

        steps.push_back(reg_step(STEP_READ, `RVFI_REG_RETIRED, 32'd0));
        steps.push_back(insn_step(32'h00100093, 3'd0, 32'h80000000, 5'd1, 32'd1,
                                  1'b0, 32'd0, 1'b0, PRIV_M, 1'b0, 1'b0)); // Trace off.
        steps.push_back(reg_step(STEP_WRITE, `RVFI_REG_CTRL, 32'd1));
        steps.push_back(reg_step(STEP_WRITE, `RVFI_REG_PRIV_MASK, 32'd7));
        steps.push_back(reg_step(STEP_READ, `RVFI_REG_CTRL, 32'd1));
        steps.push_back(reg_step(STEP_READ, `RVFI_REG_PRIV_MASK, 32'd7));
        steps.push_back(reg_step(STEP_READ, 2'd3, 32'd0)); // Unmapped address.
        steps.push_back(insn_step(32'h00500293, 3'd1, 32'h80000004, 5'd5, 32'd5,
                                  1'b0, 32'd0, 1'b0, PRIV_M, 1'b0, 1'b1));
        steps.push_back(insn_step(32'h00700013, 3'd2, 32'h80000008, 5'd0, 32'd7,
                                  1'b0, 32'd0, 1'b0, PRIV_S, 1'b0, 1'b1)); // Write to x0.
        steps.push_back(insn_step(32'h00000073, 3'd3, 32'h8000000c, 5'd3, 32'hdeadbeef,
                                  1'b0, 32'd0, 1'b1, PRIV_U, 1'b0, 1'b1)); // Trap.
        steps.push_back(insn_step(32'h0002a503, 3'd4, 32'h80000010, 5'd10, 32'h12345678,
                                  1'b1, 32'h00001f00, 1'b0, PRIV_M, 1'b0, 1'b1));
        steps.push_back(reg_step(STEP_WRITE, `RVFI_REG_PRIV_MASK, 32'd4));
        steps.push_back(insn_step(32'h00a00593, 3'd5, 32'h00010000, 5'd11, 32'd10,
                                  1'b0, 32'd0, 1'b0, PRIV_U, 1'b0, 1'b0)); // Filtered.
        steps.push_back(insn_step(32'h00b00613, 3'd6, 32'h80000014, 5'd12, 32'd11,
                                  1'b0, 32'd0, 1'b0, PRIV_M, 1'b0, 1'b1));
        steps.push_back(insn_step(32'h00c00693, 3'd2, 32'h80000018, 5'd13, 32'd12,
                                  1'b0, 32'd0, 1'b0, PRIV_M, 1'b1, 1'b0)); // Flushed.
        steps.push_back(insn_step(32'h00d00713, 3'd2, 32'h80000018, 5'd14, 32'd13,
                                  1'b0, 32'd0, 1'b0, PRIV_M, 1'b0, 1'b1));
        steps.push_back(reg_step(STEP_READ, `RVFI_REG_RETIRED, 32'd6));
        steps.push_back(reg_step(STEP_WRITE, `RVFI_REG_RETIRED, 32'h55));
        steps.push_back(reg_step(STEP_READ, `RVFI_REG_RETIRED, 32'd6));
        n_rows = steps.size();

        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;

        foreach (steps[i]) begin
            errs_before = err_cnt;
            case (steps[i].kind)
                STEP_WRITE: begin
                    @(posedge clk_i);
                    reg_we_i    <= 1'b1;
                    reg_addr_i  <= steps[i].addr;
                    reg_wdata_i <= steps[i].data;
                    @(posedge clk_i);
                    reg_we_i <= 1'b0;
                end
                STEP_READ: begin
                    @(posedge clk_i);
                    reg_addr_i <= steps[i].addr;
                    @(negedge clk_i); // Read data is combinational.
                    check_xlen("reg_rdata_o", reg_rdata_o, steps[i].data);
                end
                default: apply_insn(steps[i]);
            endcase
            if (err_cnt == errs_before) begin
                pass_rows++;
                $display("Row %0d ok", i);
            end else begin
                fail_rows++;
                $display("Row %0d mismatch", i);
            end
        end

        $display("Rows: %0d ok, %0d mismatched, %0d errors", pass_rows, fail_rows, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog with a budget of 40 cycles per table row.
    initial begin
        wait (n_rows != 0);
        repeat (n_rows * 40 + 10) @(posedge clk_i);
        $display("Timeout: the table did not finish in its cycle budget");
        $display("test failed");
        $finish;
    end

endmodule

//--- rtl/rvfi_cfg.svh
// Widths and register map of the tracer; the table depth is two to the power of the id width.
`ifndef RVFI_CFG_SVH
`define RVFI_CFG_SVH

// Data and address width of the traced core.
`define RVFI_XLEN 32

// Width of the scoreboard transaction id.
`define RVFI_TRANS_ID_BITS 3

// Addresses of the trace configuration registers.
`define RVFI_REG_CTRL      2'd0
`define RVFI_REG_PRIV_MASK 2'd1
`define RVFI_REG_RETIRED   2'd2

`endif

//--- rtl/rvfi_pkg.sv
// Types for a single-commit in-order core; widths come from rvfi_cfg.svh.
`include "rvfi_cfg.svh"

package rvfi_pkg;

    typedef logic [`RVFI_XLEN-1:0]          xlen_t;     // Data or address word.
    typedef logic [31:0]                    insn_t;     // Full instruction word.
    typedef logic [`RVFI_TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [4:0]                     reg_addr_t; // Architectural register number.

    // Privilege levels as encoded by the core.
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_lvl_t;

    // Bit 0 enables U, bit 1 enables S and bit 2 enables M.
    typedef logic [2:0] priv_mask_t;

    // Addresses of the trace configuration registers.
    typedef enum logic [1:0] {
        REG_CTRL      = `RVFI_REG_CTRL,
        REG_PRIV_MASK = `RVFI_REG_PRIV_MASK,
        REG_RETIRED   = `RVFI_REG_RETIRED
    } trace_reg_e;

    // What the core presents on its commit port.
    typedef struct packed {
        trans_id_t trans_id;
        xlen_t     pc;
        reg_addr_t rd;
        xlen_t     result;
        logic      is_mem;
        xlen_t     mem_addr;
    } commit_instr_t;

    // Probe bundle handed from the probe block to the retire stage.
    typedef struct packed {
        logic      commit_valid;
        trans_id_t trans_id;
        insn_t     insn;
        logic      insn_valid;   // Table entry was issued and not flushed.
        logic      is_compressed;
        xlen_t     pc;
        reg_addr_t rd;
        xlen_t     result;
        logic      is_mem;
        xlen_t     mem_addr;
        logic      ex_valid;
        priv_lvl_t priv_lvl;
    } rvfi_probes_t;

    // One retirement record per committed instruction.
    typedef struct packed {
        logic        valid;
        logic [63:0] order;
        insn_t       insn;
        logic        trap;
        priv_lvl_t   mode;
        reg_addr_t   rd_addr;
        xlen_t       rd_wdata;
        xlen_t       pc_rdata;
        xlen_t       mem_addr;
    } rvfi_instr_t;

endpackage

//--- rtl/rvfi_probes.sv
// One issue and one commit per cycle at most; an entry issued at edge N is seen by commits from N+1.
module rvfi_probes
    import rvfi_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          flush_i,
    input  logic          issue_valid_i,
    input  logic          issue_compressed_i,
    input  trans_id_t     issue_pointer_i,
    input  insn_t         issue_insn_i,
    input  logic          commit_ack_i,
    input  commit_instr_t commit_instr_i,
    input  logic          ex_valid_i,
    input  priv_lvl_t     priv_lvl_i,
    output rvfi_probes_t  probes_o
);

    // One table entry per transaction id.
    localparam int unsigned tbl_depth = 2 ** $bits(trans_id_t);

    insn_t                tbl_insn_q [tbl_depth];
    logic [tbl_depth-1:0] tbl_compressed_q;
    logic [tbl_depth-1:0] tbl_valid_q;

    rvfi_probes_t probe_d;
    rvfi_probes_t probe_q;

    // The instruction word and its compressed flag are captured at issue.
    always_ff @(posedge clk_i) begin
        if (issue_valid_i) begin
            tbl_insn_q[issue_pointer_i]       <= issue_insn_i;
            tbl_compressed_q[issue_pointer_i] <= issue_compressed_i;
        end
    end

    // A flush drops every entry, but an issue in the same cycle still lands.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tbl_valid_q <= '0;
        end else begin
            if (flush_i) begin
                tbl_valid_q <= '0;
            end
            if (issue_valid_i) begin
                tbl_valid_q[issue_pointer_i] <= 1'b1; // Later assignment wins over the flush.
            end
        end
    end

    // Gather the commit-side signals and the matching table entry into one bundle.
    always_comb begin
        probe_d = '0; // Anything not listed below stays zero.

        probe_d.commit_valid  = commit_ack_i;
        probe_d.trans_id      = commit_instr_i.trans_id;

        // Lookup by the id of the committing instruction.
        probe_d.insn          = tbl_insn_q[commit_instr_i.trans_id];
        probe_d.insn_valid    = tbl_valid_q[commit_instr_i.trans_id];
        probe_d.is_compressed = tbl_compressed_q[commit_instr_i.trans_id];

        probe_d.pc            = commit_instr_i.pc;
        probe_d.rd            = commit_instr_i.rd;
        probe_d.result        = commit_instr_i.result;
        probe_d.is_mem        = commit_instr_i.is_mem;
        probe_d.mem_addr      = commit_instr_i.mem_addr;

        probe_d.ex_valid      = ex_valid_i;
        probe_d.priv_lvl      = priv_lvl_i;
    end

    // Registering the bundle makes commit_valid a clean one-cycle pulse.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            probe_q <= '0;
        end else begin
            probe_q <= probe_d;
        end
    end

    assign probes_o = probe_q;

endmodule

//--- rtl/rvfi_retire.sv
// Records leave as a one-cycle valid pulse with no back-pressure; the 64-bit order never wraps.
module rvfi_retire
    import rvfi_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  rvfi_probes_t probes_i,
    input  logic         trace_en_i,
    input  priv_mask_t   priv_mask_i,
    output rvfi_instr_t  rvfi_o,
    output xlen_t        retired_cnt_o
);

    logic        mask_hit;
    logic        fire;
    logic [63:0] order_q;
    rvfi_instr_t rec_d;
    rvfi_instr_t rec_q;

    // Select the filter bit that belongs to the privilege level of this commit.
    always_comb begin
        case (probes_i.priv_lvl)
            PRIV_U:  mask_hit = priv_mask_i[0];
            PRIV_S:  mask_hit = priv_mask_i[1];
            PRIV_M:  mask_hit = priv_mask_i[2];
            default: mask_hit = 1'b0; // Reserved level is never traced.
        endcase
    end

    // A record goes out only for a known instruction that passes both filters.
    assign fire = probes_i.commit_valid & probes_i.insn_valid & trace_en_i & mask_hit;

    always_comb begin
        rec_d = '0;

        rec_d.valid    = fire;
        rec_d.order    = order_q;
        rec_d.trap     = probes_i.ex_valid;
        rec_d.mode     = probes_i.priv_lvl;
        rec_d.pc_rdata = probes_i.pc;

        // A compressed instruction keeps only its low half, as RVFI expects.
        if (probes_i.is_compressed) begin
            rec_d.insn = {16'b0, probes_i.insn[15:0]};
        end else begin
            rec_d.insn = probes_i.insn;
        end

        // A trapped instruction writes no register.
        if (!probes_i.ex_valid) begin
            rec_d.rd_addr = probes_i.rd;
            if (probes_i.rd != '0) begin
                rec_d.rd_wdata = probes_i.result; // Writes to x0 are reported as zero.
            end
        end

        if (probes_i.is_mem) begin
            rec_d.mem_addr = probes_i.mem_addr;
        end
    end

    // Only the valid flag and the order field of the record are cleared by reset.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rec_q.valid <= 1'b0;
            rec_q.order <= '0;
        end else begin
            rec_q <= rec_d;
        end
    end

    // The order counter moves only when a record is actually emitted.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            order_q <= '0;
        end else if (fire) begin
            order_q <= order_q + 64'd1;
        end
    end

    assign rvfi_o        = rec_q;
    assign retired_cnt_o = xlen_t'(order_q); // Low word of the counter.

endmodule

//--- rtl/rvfi_trace_regs.sv
// Three registers at word index 0 to 2; reads are combinational and unmapped addresses read zero.
module rvfi_trace_regs
    import rvfi_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       reg_we_i,
    input  logic [1:0] reg_addr_i,
    input  xlen_t      reg_wdata_i,
    input  xlen_t      retired_cnt_i,
    output xlen_t      reg_rdata_o,
    output logic       trace_en_o,
    output priv_mask_t priv_mask_o
);

    trace_reg_e reg_sel;
    logic       trace_en_q;
    priv_mask_t priv_mask_q;

    assign reg_sel = trace_reg_e'(reg_addr_i);

    // Write port.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            trace_en_q  <= 1'b0;
            priv_mask_q <= '0;
        end else if (reg_we_i) begin
            case (reg_sel)
                REG_CTRL:      trace_en_q  <= reg_wdata_i[0];
                REG_PRIV_MASK: priv_mask_q <= reg_wdata_i[2:0];
                REG_RETIRED:   ; // Read-only counter.
                default:       ;
            endcase
        end
    end

    // Read port.
    always_comb begin
        reg_rdata_o = '0;
        case (reg_sel)
            REG_CTRL:      reg_rdata_o[0]   = trace_en_q;
            REG_PRIV_MASK: reg_rdata_o[2:0] = priv_mask_q;
            REG_RETIRED:   reg_rdata_o      = retired_cnt_i;
            default:       reg_rdata_o      = '0;
        endcase
    end

    assign trace_en_o  = trace_en_q;
    assign priv_mask_o = priv_mask_q;

endmodule

//--- rtl/rvfi_tracer.sv
// Fixed two-cycle latency from commit to record; the core must drive all commit inputs in one cycle.
module rvfi_tracer
    import rvfi_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          flush_i,
    input  logic          issue_valid_i,
    input  trans_id_t     issue_pointer_i,
    input  insn_t         issue_insn_i,
    input  logic          issue_compressed_i,
    input  logic          commit_ack_i,
    input  commit_instr_t commit_instr_i,
    input  logic          ex_valid_i,
    input  priv_lvl_t     priv_lvl_i,
    input  logic          reg_we_i,
    input  logic [1:0]    reg_addr_i,
    input  xlen_t         reg_wdata_i,
    output xlen_t         reg_rdata_o,
    output rvfi_instr_t   rvfi_o
);

    rvfi_probes_t probes;
    logic         trace_en;
    priv_mask_t   priv_mask;
    xlen_t        retired_cnt;

    rvfi_probes u_probes (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .issue_valid_i     (issue_valid_i),
        .issue_compressed_i(issue_compressed_i),
        .issue_pointer_i   (issue_pointer_i),
        .issue_insn_i      (issue_insn_i),
        .commit_ack_i      (commit_ack_i),
        .commit_instr_i    (commit_instr_i),
        .ex_valid_i        (ex_valid_i),
        .priv_lvl_i        (priv_lvl_i),
        .probes_o          (probes)
    );

    rvfi_retire u_retire (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .probes_i     (probes),
        .trace_en_i   (trace_en),
        .priv_mask_i  (priv_mask),
        .rvfi_o       (rvfi_o),
        .retired_cnt_o(retired_cnt)
    );

    // Configuration registers steer the retire stage and read back its count.
    rvfi_trace_regs u_regs (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .reg_we_i     (reg_we_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .retired_cnt_i(retired_cnt),
        .reg_rdata_o  (reg_rdata_o),
        .trace_en_o   (trace_en),
        .priv_mask_o  (priv_mask)
    );

endmodule

//--- vlog.f
+incdir+rtl
rtl/rvfi_pkg.sv
rtl/rvfi_probes.sv
rtl/rvfi_retire.sv
rtl/rvfi_trace_regs.sv
rtl/rvfi_tracer.sv
bench/rvfi_tracer_sva.sv
bench/rvfi_tracer_tb.sv
